// ==== verilog/archimedes_io_pkg.sv ====
`default_nettype none

package archimedes_io_pkg;

	// bus and register widths
	localparam int ADDR_W      = 26;
	localparam int WB_DATA_W   = 32;
	localparam int REG_IDX_W   = 5;
	localparam int IO_DATA_W   = 8;
	localparam int TIMER_W     = 16;
	localparam int CTRL_W      = 6;
	localparam int JOY_W       = 5;
	// byte lane the cpu uses for i/o writes
	localparam int WR_LANE_LSB = 16;

	// decode constants
	localparam logic [3:0]        IO_REGION   = 4'b1100;
	localparam logic [2:0]        IOC_BANK    = 3'd0;
	localparam logic [2:0]        LATCH_BANK  = 3'd5;
	localparam logic [1:0]        LATCH_SPEED = 2'd2;
	localparam logic [ADDR_W-1:0] IO_BASE     = {IO_REGION, 22'h000000};
	localparam logic [ADDR_W-1:0] IO_LAST     = {IO_REGION, 22'h3fffff};

	// ioc word indices
	localparam logic [REG_IDX_W-1:0] REG_CTRL      = 5'd0;
	localparam logic [REG_IDX_W-1:0] REG_IRQA_STAT = 5'd4;
	localparam logic [REG_IDX_W-1:0] REG_IRQA_REQ  = 5'd5;
	localparam logic [REG_IDX_W-1:0] REG_IRQA_MASK = 5'd6;
	localparam logic [REG_IDX_W-1:0] REG_IRQB_STAT = 5'd8;
	localparam logic [REG_IDX_W-1:0] REG_IRQB_REQ  = 5'd9;
	localparam logic [REG_IDX_W-1:0] REG_IRQB_MASK = 5'd10;
	localparam logic [REG_IDX_W-1:0] REG_FIQ_STAT  = 5'd12;
	localparam logic [REG_IDX_W-1:0] REG_FIQ_REQ   = 5'd13;
	localparam logic [REG_IDX_W-1:0] REG_FIQ_MASK  = 5'd14;
	localparam logic [REG_IDX_W-1:0] REG_T0_LOW    = 5'd16;
	localparam logic [REG_IDX_W-1:0] REG_T0_HIGH   = 5'd17;
	localparam logic [REG_IDX_W-1:0] REG_T0_GO     = 5'd18;

	// external latch indices
	localparam logic [REG_IDX_W-1:0] REG_LATCH_A = 5'd0;
	localparam logic [REG_IDX_W-1:0] REG_LATCH_C = 5'd2;
	localparam logic [REG_IDX_W-1:0] REG_JOY     = 5'd4;

	// irq a bit positions
	localparam int IRQA_FLYBK = 3;
	localparam int IRQA_POR   = 4;
	localparam int IRQA_TM0   = 5;

	// cpu byte address, top bits first
	typedef struct packed {
		logic [3:0]  region;
		logic        ioc_sel;
		logic [1:0]  speed;
		logic [2:0]  bank;
		logic [13:0] offset;
		logic [1:0]  byte_lane;
	} io_addr_fields_t;

	typedef union packed {
		logic [ADDR_W-1:0] raw;
		io_addr_fields_t   f;
	} io_addr_t;

endpackage

`default_nettype wire

// ==== verilog/io_bus_if.sv ====
`default_nettype none

// register bus from the decoder to one i/o block
interface io_bus_if import archimedes_io_pkg::*; ();

	// single cycle access pulse
	logic                 stb;
	logic                 we;
	logic [REG_IDX_W-1:0] reg_idx;
	logic [IO_DATA_W-1:0] wdata;
	// combinational read data for the current reg_idx
	logic [IO_DATA_W-1:0] rdata;

	modport master (
		output stb,
		output we,
		output reg_idx,
		output wdata,
		input  rdata
	);

	modport slave (
		input  stb,
		input  we,
		input  reg_idx,
		input  wdata,
		output rdata
	);

endinterface

`default_nettype wire

// ==== verilog/io_decoder.sv ====
`default_nettype none

module io_decoder import archimedes_io_pkg::*; (
	input  wire                   clkcpu_i,
	input  wire                   rst_n_i,

	// wishbone slave port
	input  wire                   cyc_i,
	input  wire                   stb_i,
	input  wire                   we_i,
	input  wire [ADDR_W-1:0]      adr_i,
	input  wire [WB_DATA_W-1:0]   dat_i,
	input  wire                   spvmd_i,
	output logic                  ack_o,
	output logic                  err_o,
	output logic [WB_DATA_W-1:0]  dat_o,

	io_bus_if.master              ioc_bus,
	io_bus_if.master              latch_bus
);

	io_addr_t             addr;
	logic                 req;
	logic                 in_io;
	logic                 access_ok;
	logic                 ioc_hit;
	logic                 latch_hit;
	logic [WB_DATA_W-1:0] rd_word;

	assign addr = adr_i;

	// new request, ignored while it is being answered
	assign req = cyc_i & stb_i & ~ack_o & ~err_o;

	assign in_io     = (addr.raw >= IO_BASE) && (addr.raw <= IO_LAST);
	// user mode may not touch i/o space
	assign access_ok = in_io & spvmd_i;

	assign ioc_hit   = addr.f.ioc_sel && (addr.f.bank == IOC_BANK);
	assign latch_hit = addr.f.ioc_sel && (addr.f.bank == LATCH_BANK) &&
		(addr.f.speed == LATCH_SPEED);

	assign ioc_bus.stb     = req & access_ok & ioc_hit;
	assign ioc_bus.we      = we_i;
	assign ioc_bus.reg_idx = addr.f.offset[REG_IDX_W-1:0];
	assign ioc_bus.wdata   = dat_i[WR_LANE_LSB +: IO_DATA_W];

	assign latch_bus.stb     = req & access_ok & latch_hit;
	assign latch_bus.we      = we_i;
	assign latch_bus.reg_idx = addr.f.offset[REG_IDX_W-1:0];
	assign latch_bus.wdata   = dat_i[WR_LANE_LSB +: IO_DATA_W];

	// unmapped space floats high
	always_comb begin
		if (ioc_hit) begin
			rd_word = {{(WB_DATA_W-IO_DATA_W){1'b0}}, ioc_bus.rdata};
		end else if (latch_hit) begin
			rd_word = {{(WB_DATA_W-IO_DATA_W){1'b0}}, latch_bus.rdata};
		end else begin
			rd_word = '1;
		end
	end

	always_ff @(posedge clkcpu_i) begin
		if (!rst_n_i) begin
			ack_o <= 1'b0;
			err_o <= 1'b0;
		end else begin
			ack_o <= req & access_ok;
			err_o <= req & ~access_ok;
		end
	end

	always_ff @(posedge clkcpu_i) begin
		if (req) begin
			dat_o <= rd_word;
		end
	end

	a_ack_err_excl : assert property (@(posedge clkcpu_i) disable iff (!rst_n_i)
		!(ack_o && err_o));

	// response only while the master still holds the cycle
	a_resp_in_cyc : assert property (@(posedge clkcpu_i) disable iff (!rst_n_i)
		(ack_o || err_o) |-> cyc_i);

endmodule

`default_nettype wire

// ==== verilog/ioc_regs.sv ====
`default_nettype none

module ioc_regs import archimedes_io_pkg::*; (
	input  wire                  clkcpu_i,
	input  wire                  rst_n_i,

	io_bus_if.slave              bus,

	input  wire                  flybk_i,
	input  wire [IO_DATA_W-1:0]  irq_b_i,
	input  wire [IO_DATA_W-1:0]  fiq_i,

	input  wire [CTRL_W-1:0]     ctrl_i,
	output logic [CTRL_W-1:0]    ctrl_o,

	output logic                 irq_o,
	output logic                 firq_o
);

	logic                 wr;
	logic                 flybk_q;
	logic [IO_DATA_W-1:0] irqa_stat;
	logic [IO_DATA_W-1:0] irqa_mask;
	logic [IO_DATA_W-1:0] irqb_mask;
	logic [IO_DATA_W-1:0] fiq_mask;
	logic [IO_DATA_W-1:0] irqa_set;
	logic [IO_DATA_W-1:0] irqa_clr;
	logic [IO_DATA_W-1:0] irqa_req;
	logic [IO_DATA_W-1:0] irqb_req;
	logic [IO_DATA_W-1:0] fiq_req;
	logic [TIMER_W-1:0]   t0_latch;
	logic [TIMER_W-1:0]   t0_count;
	logic                 t0_run;
	logic                 t0_fire;

	assign wr = bus.stb & bus.we;

	assign t0_fire = t0_run && (t0_count == '0);

	// edge and timer events into irq a
	always_comb begin
		irqa_set             = '0;
		irqa_set[IRQA_FLYBK] = flybk_i & ~flybk_q;
		irqa_set[IRQA_TM0]   = t0_fire;
	end

	// writing ones to the request register clears status
	assign irqa_clr = (wr && bus.reg_idx == REG_IRQA_REQ) ? bus.wdata : '0;

	assign irqa_req = irqa_stat & irqa_mask;
	assign irqb_req = irq_b_i & irqb_mask;
	assign fiq_req  = fiq_i & fiq_mask;

	always_ff @(posedge clkcpu_i) begin
		if (!rst_n_i) begin
			flybk_q             <= 1'b0;
			irqa_stat           <= '0;
			irqa_stat[IRQA_POR] <= 1'b1;
			irqa_mask           <= '0;
			irqb_mask           <= '0;
			fiq_mask            <= '0;
			ctrl_o              <= '1;
		end else begin
			flybk_q   <= flybk_i;
			// a new event wins over a clear in the same cycle
			irqa_stat <= (irqa_stat & ~irqa_clr) | irqa_set;
			if (wr) begin
				case (bus.reg_idx)
					REG_CTRL:      ctrl_o    <= bus.wdata[CTRL_W-1:0];
					REG_IRQA_MASK: irqa_mask <= bus.wdata;
					REG_IRQB_MASK: irqb_mask <= bus.wdata;
					REG_FIQ_MASK:  fiq_mask  <= bus.wdata;
					default: ;
				endcase
			end
		end
	end

	// reload value, loaded a byte at a time
	always_ff @(posedge clkcpu_i) begin
		if (wr && bus.reg_idx == REG_T0_LOW) begin
			t0_latch[IO_DATA_W-1:0] <= bus.wdata;
		end
		if (wr && bus.reg_idx == REG_T0_HIGH) begin
			t0_latch[TIMER_W-1:IO_DATA_W] <= bus.wdata;
		end
	end

	// timer 0, idle until the first go
	always_ff @(posedge clkcpu_i) begin
		if (!rst_n_i) begin
			t0_run   <= 1'b0;
			t0_count <= '0;
		end else if (wr && bus.reg_idx == REG_T0_GO) begin
			t0_run   <= 1'b1;
			t0_count <= t0_latch;
		end else if (t0_run) begin
			t0_count <= t0_fire ? t0_latch : t0_count - 1'b1;
		end
	end

	always_ff @(posedge clkcpu_i) begin
		if (!rst_n_i) begin
			irq_o  <= 1'b0;
			firq_o <= 1'b0;
		end else begin
			irq_o  <= (|irqa_req) | (|irqb_req);
			firq_o <= |fiq_req;
		end
	end

	always_comb begin
		case (bus.reg_idx)
			REG_CTRL:      bus.rdata = {{(IO_DATA_W-CTRL_W){1'b0}}, ctrl_i};
			REG_IRQA_STAT: bus.rdata = irqa_stat;
			REG_IRQA_REQ:  bus.rdata = irqa_req;
			REG_IRQA_MASK: bus.rdata = irqa_mask;
			REG_IRQB_STAT: bus.rdata = irq_b_i;
			REG_IRQB_REQ:  bus.rdata = irqb_req;
			REG_IRQB_MASK: bus.rdata = irqb_mask;
			REG_FIQ_STAT:  bus.rdata = fiq_i;
			REG_FIQ_REQ:   bus.rdata = fiq_req;
			REG_FIQ_MASK:  bus.rdata = fiq_mask;
			REG_T0_LOW:    bus.rdata = t0_count[IO_DATA_W-1:0];
			REG_T0_HIGH:   bus.rdata = t0_count[TIMER_W-1:IO_DATA_W];
			default:       bus.rdata = '0;
		endcase
	end

	// decoder must present a settled index with every pulse
	a_idx_known : assert property (@(posedge clkcpu_i) disable iff (!rst_n_i)
		bus.stb |-> !$isunknown(bus.reg_idx));

endmodule

`default_nettype wire

// ==== verilog/ext_latches.sv ====
`default_nettype none

module ext_latches import archimedes_io_pkg::*; (
	input  wire                  clkcpu_i,
	input  wire                  rst_n_i,

	io_bus_if.slave              bus,

	// floppy control from latch a
	output logic [3:0]           floppy_drive_o,
	output logic                 floppy_side_o,
	output logic                 floppy_motor_o,
	output logic                 floppy_inuse_o,
	output logic                 floppy_reset_o,

	// video enhancer from latch c
	output logic [1:0]           vid_baseclk_o,
	output logic [1:0]           vid_syncpol_o,

	input  wire [JOY_W-1:0]      joy0_i,
	input  wire [JOY_W-1:0]      joy1_i
);

	logic                 wr;
	logic [IO_DATA_W-1:0] latch_a;
	logic [IO_DATA_W-1:0] latch_c;

	assign wr = bus.stb & bus.we;

	// drive select is active low, so all drives start deselected
	always_ff @(posedge clkcpu_i) begin
		if (!rst_n_i) begin
			latch_a <= 8'h0f;
			latch_c <= '0;
		end else if (wr) begin
			case (bus.reg_idx)
				REG_LATCH_A: latch_a <= bus.wdata;
				REG_LATCH_C: latch_c <= bus.wdata;
				default: ;
			endcase
		end
	end

	assign floppy_drive_o = latch_a[3:0];
	assign floppy_side_o  = latch_a[4];
	assign floppy_motor_o = latch_a[5];
	assign floppy_inuse_o = latch_a[6];
	assign floppy_reset_o = latch_a[7];

	assign vid_baseclk_o = latch_c[1:0];
	assign vid_syncpol_o = latch_c[3:2];

	always_comb begin
		case (bus.reg_idx)
			REG_LATCH_A:        bus.rdata = latch_a;
			REG_LATCH_C:        bus.rdata = latch_c;
			REG_JOY:            bus.rdata = {{(IO_DATA_W-JOY_W){1'b0}}, joy0_i};
			REG_JOY + 5'd1:     bus.rdata = {{(IO_DATA_W-JOY_W){1'b0}}, joy1_i};
			default:            bus.rdata = '1;
		endcase
	end

	// joystick port is read only
	a_no_joy_write : assert property (@(posedge clkcpu_i) disable iff (!rst_n_i)
		!(wr && bus.reg_idx == REG_JOY));

endmodule

`default_nettype wire

// ==== verilog/archimedes_io_top.sv ====
`default_nettype none

module archimedes_io_top import archimedes_io_pkg::*; (
	input  wire                  clkcpu_i,
	input  wire                  rst_n_i,

	// cpu wishbone port
	input  wire                  cyc_i,
	input  wire                  stb_i,
	input  wire                  we_i,
	input  wire [ADDR_W-1:0]     adr_i,
	input  wire [WB_DATA_W-1:0]  dat_i,
	input  wire                  spvmd_i,
	output wire                  ack_o,
	output wire                  err_o,
	output wire [WB_DATA_W-1:0]  dat_o,

	// interrupt sources and cpu interrupts
	input  wire                  flybk_i,
	input  wire [IO_DATA_W-1:0]  irq_b_i,
	input  wire [IO_DATA_W-1:0]  fiq_i,
	output wire                  irq_o,
	output wire                  firq_o,

	input  wire [CTRL_W-1:0]     ctrl_i,
	output wire [CTRL_W-1:0]     ctrl_o,

	output wire [3:0]            floppy_drive_o,
	output wire                  floppy_side_o,
	output wire                  floppy_motor_o,
	output wire                  floppy_inuse_o,
	output wire                  floppy_reset_o,

	output wire [1:0]            vid_baseclk_o,
	output wire [1:0]            vid_syncpol_o,

	input  wire [JOY_W-1:0]      joy0_i,
	input  wire [JOY_W-1:0]      joy1_i
);

	io_bus_if ioc_bus ();
	io_bus_if latch_bus ();

	io_decoder io_decoder_i (
		.clkcpu_i  ( clkcpu_i  ),
		.rst_n_i   ( rst_n_i   ),
		.cyc_i     ( cyc_i     ),
		.stb_i     ( stb_i     ),
		.we_i      ( we_i      ),
		.adr_i     ( adr_i     ),
		.dat_i     ( dat_i     ),
		.spvmd_i   ( spvmd_i   ),
		.ack_o     ( ack_o     ),
		.err_o     ( err_o     ),
		.dat_o     ( dat_o     ),
		.ioc_bus   ( ioc_bus   ),
		.latch_bus ( latch_bus )
	);

	ioc_regs ioc_regs_i (
		.clkcpu_i  ( clkcpu_i  ),
		.rst_n_i   ( rst_n_i   ),
		.bus       ( ioc_bus   ),
		.flybk_i   ( flybk_i   ),
		.irq_b_i   ( irq_b_i   ),
		.fiq_i     ( fiq_i     ),
		.ctrl_i    ( ctrl_i    ),
		.ctrl_o    ( ctrl_o    ),
		.irq_o     ( irq_o     ),
		.firq_o    ( firq_o    )
	);

	ext_latches ext_latches_i (
		.clkcpu_i       ( clkcpu_i       ),
		.rst_n_i        ( rst_n_i        ),
		.bus            ( latch_bus      ),
		.floppy_drive_o ( floppy_drive_o ),
		.floppy_side_o  ( floppy_side_o  ),
		.floppy_motor_o ( floppy_motor_o ),
		.floppy_inuse_o ( floppy_inuse_o ),
		.floppy_reset_o ( floppy_reset_o ),
		.vid_baseclk_o  ( vid_baseclk_o  ),
		.vid_syncpol_o  ( vid_syncpol_o  ),
		.joy0_i         ( joy0_i         ),
		.joy1_i         ( joy1_i         )
	);

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`default_nettype none

module tb_clock (
	output logic clk_o,
	output logic rst_n_o
);

	// period of 20
	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o;
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (16) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== tests/tb_archimedes_io.sv ====
`default_nettype none

module tb_archimedes_io import archimedes_io_pkg::*; ();

	localparam int BUS_TIMEOUT = 20;
	localparam int IRQ_TIMEOUT = 1000;

	wire                  clk;
	wire                  rst_n;
	logic                 cyc, stb, we, spvmd, flybk;
	logic [ADDR_W-1:0]    adr;
	logic [WB_DATA_W-1:0] dat;
	logic [7:0]           irq_b, fiq;
	logic [JOY_W-1:0]     joy0, joy1;
	wire                  ack, err, irq, firq;
	wire [WB_DATA_W-1:0]  dat_o;
	wire [CTRL_W-1:0]     ctrl_o;
	wire [3:0]            fd_drive;
	wire                  fd_side, fd_motor, fd_inuse, fd_reset;
	wire [1:0]            vid_baseclk, vid_syncpol;

	// model state
	logic [7:0] m_irqa_stat, m_irqa_mask, m_irqb_mask, m_fiq_mask;
	logic [7:0] m_latch_a, m_latch_c;
	logic [5:0] m_ctrl;

	// pending compares
	string          q_name[$];
	logic [31:0]    q_exp[$];
	logic [31:0]    q_act[$];
	time            q_time[$];
	int             errors = 0;
	int             checks = 0;

	tb_clock tb_clock_i (.clk_o(clk), .rst_n_o(rst_n));

	archimedes_io_top archimedes_io_top_i (
		.clkcpu_i(clk), .rst_n_i(rst_n),
		.cyc_i(cyc), .stb_i(stb), .we_i(we), .adr_i(adr), .dat_i(dat), .spvmd_i(spvmd),
		.ack_o(ack), .err_o(err), .dat_o(dat_o),
		.flybk_i(flybk), .irq_b_i(irq_b), .fiq_i(fiq), .irq_o(irq), .firq_o(firq),
		.ctrl_i(ctrl_o), .ctrl_o(ctrl_o),
		.floppy_drive_o(fd_drive), .floppy_side_o(fd_side), .floppy_motor_o(fd_motor),
		.floppy_inuse_o(fd_inuse), .floppy_reset_o(fd_reset),
		.vid_baseclk_o(vid_baseclk), .vid_syncpol_o(vid_syncpol),
		.joy0_i(joy0), .joy1_i(joy1)
	);

	function automatic logic [ADDR_W-1:0] ioc_addr(input logic [4:0] idx);
		return {IO_REGION, 1'b1, 2'b00, IOC_BANK, 9'd0, idx, 2'b00};
	endfunction

	function automatic logic [ADDR_W-1:0] latch_addr(input logic [4:0] idx);
		return {IO_REGION, 1'b1, LATCH_SPEED, LATCH_BANK, 9'd0, idx, 2'b00};
	endfunction

	// predicted read data from the register rules
	function automatic logic [31:0] expected_read(input logic is_latch, input logic [4:0] idx);
		logic [7:0] v;
		if (is_latch) begin
			case (idx)
				5'd0: v = m_latch_a;
				5'd2: v = m_latch_c;
				5'd4: v = {3'b000, joy0};
				5'd5: v = {3'b000, joy1};
				default: v = 8'hff;
			endcase
		end else begin
			case (idx)
				5'd0: v = {2'b00, m_ctrl};
				5'd4: v = m_irqa_stat;
				5'd5: v = m_irqa_stat & m_irqa_mask;
				5'd6: v = m_irqa_mask;
				5'd8: v = irq_b;
				5'd9: v = irq_b & m_irqb_mask;
				5'd10: v = m_irqb_mask;
				5'd12: v = fiq;
				5'd13: v = fiq & m_fiq_mask;
				5'd14: v = m_fiq_mask;
				default: v = 8'h00;
			endcase
		end
		return {24'h0, v};
	endfunction

	task automatic expect_value(input string name, input logic [31:0] e, input logic [31:0] a);
		q_name.push_back(name);
		q_exp.push_back(e);
		q_act.push_back(a);
		q_time.push_back($time);
	endtask

	// compare process
	always @(negedge clk) begin
		while (q_name.size() > 0) begin
			checks++;
			if (q_exp[0] !== q_act[0]) begin
				$display("Error at %0t: %s expected %h got %h", q_time[0], q_name[0],
					q_exp[0], q_act[0]);
				errors++;
			end
			void'(q_name.pop_front());
			void'(q_exp.pop_front());
			void'(q_act.pop_front());
			void'(q_time.pop_front());
		end
	end

	task automatic bus_access(input logic w, input logic [ADDR_W-1:0] a, input logic [7:0] wd,
		input logic sv, output logic [31:0] rd, output logic acked, output logic erred);
		int n;
		n = 0;
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= w;
		adr <= a;
		dat <= {8'h00, wd, 16'h0000};
		spvmd <= sv;
		acked = 1'b0;
		erred = 1'b0;
		while (!(acked || erred) && n < BUS_TIMEOUT) begin
			@(negedge clk);
			n++;
			acked = ack;
			erred = err;
		end
		if (!(acked || erred)) begin
			$display("timeout: no ack or err for address %h", a);
			$display("SIMULATION FAILED");
			$finish;
		end
		// response belongs in the cycle after the request
		if (n != 2) begin
			$display("response to address %h came %0d cycles late", a, n - 2);
			errors++;
		end
		rd = dat_o;
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
	endtask

	task automatic write_reg(input logic is_latch, input logic [4:0] idx, input logic [7:0] d);
		logic [31:0] rd;
		logic        a, e;
		bus_access(1'b1, is_latch ? latch_addr(idx) : ioc_addr(idx), d, 1'b1, rd, a, e);
		expect_value("ack_o", 1, {31'h0, a});
	endtask

	task automatic read_check(input logic is_latch, input logic [4:0] idx, input string name);
		logic [31:0] rd;
		logic        a, e;
		bus_access(1'b0, is_latch ? latch_addr(idx) : ioc_addr(idx), 8'h00, 1'b1, rd, a, e);
		expect_value(name, expected_read(is_latch, idx), rd);
	endtask

	task automatic check_irq_outputs();
		logic ei, ef;
		ei = |(m_irqa_stat & m_irqa_mask) | |(irq_b & m_irqb_mask);
		ef = |(fiq & m_fiq_mask);
		expect_value("irq_o", {31'h0, ei}, {31'h0, irq});
		expect_value("firq_o", {31'h0, ef}, {31'h0, firq});
	endtask

	task automatic finish_test(input string name, input int err_before);
		repeat (2) @(posedge clk);
		$display("test %s done, %0d errors", name, errors - err_before);
	endtask

	initial begin
		int          n, e0;
		logic [7:0]  d;
		logic [31:0] rd;
		logic        a, e;
		cyc = 0;
		stb = 0;
		we = 0;
		adr = '0;
		dat = '0;
		spvmd = 0;
		flybk = 0;
		irq_b = '0;
		fiq = '0;
		joy0 = '0;
		joy1 = '0;
		m_irqa_stat = 8'h10;
		m_irqa_mask = 0;
		m_irqb_mask = 0;
		m_fiq_mask = 0;
		m_latch_a = 8'h0f;
		m_latch_c = 0;
		m_ctrl = 6'h3f;
		void'($urandom(32'hd82a));
		n = 0;
		while (!rst_n && n < 100) begin
			@(posedge clk);
			n++;
		end
		if (!rst_n) begin
			$display("reset never released");
			$display("SIMULATION FAILED");
			$finish;
		end

		e0 = errors;
		@(negedge clk);
		expect_value("ack_o", 0, {31'h0, ack});
		expect_value("err_o", 0, {31'h0, err});
		check_irq_outputs();
		expect_value("ctrl_o", 32'h3f, {26'h0, ctrl_o});
		expect_value("floppy_drive_o", 32'hf, {28'h0, fd_drive});
		read_check(0, REG_IRQA_STAT, "irqa_stat");
		write_reg(0, REG_IRQA_REQ, 8'h10);
		m_irqa_stat[IRQA_POR] = 1'b0;
		read_check(0, REG_IRQA_STAT, "irqa_stat");
		finish_test("reset_por", e0);

		e0 = errors;
		repeat (8) begin
			d = 8'($urandom);
			write_reg(0, REG_CTRL, d);
			m_ctrl = d[5:0];
			@(negedge clk);
			expect_value("ctrl_o", {26'h0, m_ctrl}, {26'h0, ctrl_o});
			read_check(0, REG_CTRL, "ctrl read");
		end
		finish_test("control_port", e0);

		e0 = errors;
		repeat (8) begin
			m_irqa_mask = 8'($urandom);
			m_irqb_mask = 8'($urandom);
			m_fiq_mask = 8'($urandom);
			write_reg(0, REG_IRQA_MASK, m_irqa_mask);
			write_reg(0, REG_IRQB_MASK, m_irqb_mask);
			write_reg(0, REG_FIQ_MASK, m_fiq_mask);
			@(posedge clk);
			irq_b <= 8'($urandom);
			fiq <= 8'($urandom);
			@(posedge clk);
			@(negedge clk);
			check_irq_outputs();
			for (int i = 4; i < 15; i++) begin
				if (i % 4 != 3) begin
					read_check(0, 5'(i), $sformatf("ioc reg %0d", i));
				end
			end
		end
		@(posedge clk);
		flybk <= 1'b1;
		@(posedge clk);
		flybk <= 1'b0;
		m_irqa_stat[IRQA_FLYBK] = 1'b1;
		@(negedge clk);
		read_check(0, REG_IRQA_STAT, "irqa_stat flyback");
		write_reg(0, REG_IRQA_REQ, 8'h08);
		m_irqa_stat[IRQA_FLYBK] = 1'b0;
		read_check(0, REG_IRQA_STAT, "irqa_stat cleared");
		@(negedge clk);
		check_irq_outputs();
		finish_test("interrupts", e0);

		e0 = errors;
		@(posedge clk);
		irq_b <= '0;
		fiq <= '0;
		m_irqa_mask = 8'h20;
		write_reg(0, REG_IRQA_MASK, m_irqa_mask);
		write_reg(0, REG_T0_LOW, 8'd200);
		write_reg(0, REG_T0_HIGH, 8'd0);
		write_reg(0, REG_T0_GO, 8'd0);
		n = 0;
		while (!irq && n < IRQ_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!irq) begin
			$display("timer never raised irq_o");
			$display("SIMULATION FAILED");
			$finish;
		end
		m_irqa_stat[IRQA_TM0] = 1'b1;
		read_check(0, REG_IRQA_STAT, "irqa_stat timer");
		write_reg(0, REG_IRQA_REQ, 8'h20);
		m_irqa_stat[IRQA_TM0] = 1'b0;
		@(negedge clk);
		expect_value("irq_o", 0, {31'h0, irq});
		// the timer keeps running so mask it away from irq_o
		m_irqa_mask = 8'h00;
		write_reg(0, REG_IRQA_MASK, m_irqa_mask);
		finish_test("timer", e0);

		e0 = errors;
		repeat (8) begin
			m_latch_a = 8'($urandom);
			m_latch_c = 8'($urandom);
			write_reg(1, REG_LATCH_A, m_latch_a);
			write_reg(1, REG_LATCH_C, m_latch_c);
			@(negedge clk);
			expect_value("floppy_drive_o", {28'h0, m_latch_a[3:0]}, {28'h0, fd_drive});
			expect_value("floppy_side_o", {31'h0, m_latch_a[4]}, {31'h0, fd_side});
			expect_value("floppy_motor_o", {31'h0, m_latch_a[5]}, {31'h0, fd_motor});
			expect_value("floppy_inuse_o", {31'h0, m_latch_a[6]}, {31'h0, fd_inuse});
			expect_value("floppy_reset_o", {31'h0, m_latch_a[7]}, {31'h0, fd_reset});
			expect_value("vid_baseclk_o", {30'h0, m_latch_c[1:0]}, {30'h0, vid_baseclk});
			expect_value("vid_syncpol_o", {30'h0, m_latch_c[3:2]}, {30'h0, vid_syncpol});
			@(posedge clk);
			joy0 <= 5'($urandom);
			joy1 <= 5'($urandom);
			@(posedge clk);
			read_check(1, REG_JOY, "joy0 read");
			read_check(1, REG_JOY + 5'd1, "joy1 read");
			read_check(1, REG_LATCH_A, "latch a read");
		end
		finish_test("latches", e0);

		e0 = errors;
		bus_access(0, {IO_REGION, 22'h000040}, 8'h00, 1'b1, rd, a, e);
		expect_value("dat_o unmapped", 32'hffffffff, rd);
		expect_value("ack_o", 1, {31'h0, a});
		m_ctrl = 6'h15;
		write_reg(0, REG_CTRL, 8'h15);
		// control register address with the region bits cleared
		bus_access(1, ioc_addr(REG_CTRL) & {4'h0, 22'h3fffff}, 8'h2a, 1'b1, rd, a, e);
		expect_value("err_o outside", 1, {31'h0, e});
		expect_value("ack_o outside", 0, {31'h0, a});
		bus_access(1, ioc_addr(REG_CTRL), 8'h2a, 1'b0, rd, a, e);
		expect_value("err_o user", 1, {31'h0, e});
		expect_value("ack_o user", 0, {31'h0, a});
		read_check(0, REG_CTRL, "ctrl after denied");
		bus_access(1, latch_addr(REG_LATCH_C), 8'h5a, 1'b0, rd, a, e);
		expect_value("err_o user latch", 1, {31'h0, e});
		read_check(1, REG_LATCH_C, "latch c after denied");
		finish_test("decode_protect", e0);

		repeat (2) @(negedge clk);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/archimedes_io_pkg.sv
verilog/io_bus_if.sv
verilog/io_decoder.sv
verilog/ioc_regs.sv
verilog/ext_latches.sv
verilog/archimedes_io_top.sv
tests/tb_clock.sv
tests/tb_archimedes_io.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_archimedes_io
FILELIST  := build.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
